// File: run_sim.sh
#!/bin/sh
# build and run the scope controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_scope -o tb_scope

./obj_dir/tb_scope > sim.log 2>&1 || true
cat sim.log

# the testbench prints the pass line only when every check held
grep -q "=== PASS ===" sim.log

// File: sim.f
+incdir+src
src/scope_cmd_pkg.sv
src/scope_acq_pkg.sv
src/cmd_frame_rx.sv
src/cmd_exec.sv
src/resp_stream_tx.sv
src/trigger_fsm.sv
src/sample_ram.sv
src/scope_top.sv
test/tb_scope.sv

// File: src/cmd_exec.sv
/*
 * command executor
 * decodes a frame, keeps trigger settings and hands responses to the transmitter
 */
`timescale 1ns/1ps
`default_nettype none
`include "scope_defs.svh"

module cmd_exec import scope_cmd_pkg::*; import scope_acq_pkg::*; (
	input  logic                    clk,
	input  logic                    rstn,
	input  cmd_frame_u              i_frame,
	input  logic                    i_frame_valid,
	output logic                    o_cmd_done,
	output logic                    o_arm,
	output logic [7:0]              o_arm_type,
	output logic [`SCOPE_CNT_W-1:0] o_post_len,
	output sample_t                 o_lower,
	output sample_t                 o_upper,
	input  acq_state_t              i_acq_state,
	input  logic [`SCOPE_CNT_W-1:0] i_event_count,
	input  buf_addr_t               i_trig_addr,
	output logic                    o_resp_start,
	output logic [`SCOPE_WORD_W-1:0] o_resp_word,
	output logic [`SCOPE_LEN_W-1:0] o_resp_bytes,
	output logic                    o_resp_is_buf,
	output buf_addr_t               o_resp_addr,
	input  logic                    i_resp_done
);

	localparam logic [`SCOPE_SAMPLE_W-1:0] MID  = `SCOPE_SAMPLE_W'(128);
	localparam logic [`SCOPE_SAMPLE_W-1:0] BIAS = `SCOPE_SAMPLE_W'(8);

	logic [`SCOPE_SAMPLE_W-1:0] centre_x, hyst_x, lo_calc, hi_calc;
	logic [15:0]                preoff_full;
	buf_addr_t                  pre_off; // samples shown before the trigger
	logic                       busy;    // response in flight
	logic                       known;
	logic                       is_buf_d;
	logic [`SCOPE_WORD_W-1:0]   word_d;
	logic [`SCOPE_LEN_W-1:0]    bytes_d;

	// ------------------------------
	// threshold math, 8-bit host units to adc counts
	assign centre_x    = `SCOPE_SAMPLE_W'(i_frame.cfg.centre);
	assign hyst_x      = `SCOPE_SAMPLE_W'(i_frame.cfg.hyst);
	assign lo_calc     = ((centre_x - hyst_x - MID) << 4) + BIAS;
	assign hi_calc     = ((centre_x + hyst_x - MID) << 4) + BIAS;
	assign preoff_full = {i_frame.cfg.preoff_hi, i_frame.cfg.preoff_lo};

	always_comb begin
		word_d   = '0;
		bytes_d  = `SCOPE_LEN_W'(4); // single status word
		is_buf_d = 1'b0;
		known    = 1'b1;
		case (i_frame.rd.opcode)
			RD_BUF: begin
				is_buf_d = 1'b1;
				bytes_d  = i_frame.rd.length;
			end
			ARM:      word_d = {i_event_count, 8'd0, i_acq_state};
			RD_INFO:  word_d = `SCOPE_WORD_W'(`SCOPE_VERSION);
			TRIG_SET: word_d = `SCOPE_WORD_W'(8); // echo of the opcode
			default:  known  = 1'b0;              // silently dropped
		endcase
	end

	// ------------------------------
	// control and settings
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			busy         <= 1'b0;
			o_cmd_done   <= 1'b0;
			o_arm        <= 1'b0;
			o_resp_start <= 1'b0;
			o_arm_type   <= '0;
			o_post_len   <= '0;
			o_lower      <= '0;
			o_upper      <= '0;
			pre_off      <= '0;
		end else begin
			o_cmd_done   <= 1'b0;
			o_arm        <= 1'b0;
			o_resp_start <= 1'b0;
			if (i_frame_valid) begin
				o_resp_start <= known;
				busy         <= known;
				o_cmd_done   <= !known; // nothing to send, release rx now
				if (i_frame.rd.opcode == ARM) begin
					o_arm      <= 1'b1; // ignored by trigger unless ready
					o_arm_type <= i_frame.rd.trig_type;
					o_post_len <= i_frame.rd.length[`SCOPE_CNT_W-1:0];
				end
				if (i_frame.rd.opcode == TRIG_SET) begin
					o_lower <= lo_calc;
					o_upper <= hi_calc;
					pre_off <= preoff_full[`SCOPE_ADDR_W-1:0]; // modulo ring size
				end
			end else if (busy && i_resp_done) begin
				busy       <= 1'b0;
				o_cmd_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_frame_valid) begin
			o_resp_word   <= word_d;
			o_resp_bytes  <= bytes_d;
			o_resp_is_buf <= is_buf_d;
			o_resp_addr   <= i_trig_addr - pre_off; // wraps in the ring
		end
	end

endmodule

`default_nettype wire

// File: src/cmd_frame_rx.sv
/*
 * command receiver
 * collects 8 bytes from the host stream into one frame, holds off until done
 */
`timescale 1ns/1ps
`default_nettype none
`include "scope_defs.svh"

module cmd_frame_rx import scope_cmd_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  logic       i_rx_tvalid,
	input  logic [7:0] i_rx_tdata,
	output logic       o_rx_tready,
	output cmd_frame_u o_frame,
	output logic       o_frame_valid,
	input  logic       i_cmd_done
);

	localparam int CNT_W = $clog2(`SCOPE_FRAME_BYTES);
	localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`SCOPE_FRAME_BYTES - 1);

	logic [CNT_W-1:0] cnt;  // byte index in frame
	logic             busy; // frame handed over, command running
	logic             accept;

	assign accept = i_rx_tvalid && o_rx_tready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cnt           <= '0;
			busy          <= 1'b0;
			o_rx_tready   <= 1'b0; // low for the first cycle
			o_frame_valid <= 1'b0;
		end else begin
			o_frame_valid <= 1'b0;
			if (accept) begin
				cnt <= cnt + 1'b1; // wraps back to 0 after last byte
				if (cnt == LAST_IDX) begin
					busy          <= 1'b1;
					o_rx_tready   <= 1'b0;
					o_frame_valid <= 1'b1;
				end
			end else if (busy) begin
				if (i_cmd_done) begin
					busy        <= 1'b0;
					o_rx_tready <= 1'b1;
				end
			end else begin
				o_rx_tready <= 1'b1; // idle, between frames
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) o_frame.raw[cnt] <= i_rx_tdata; // byte lands at its index
	end

endmodule

`default_nettype wire

// File: src/resp_stream_tx.sv
/*
 * response transmitter
 * sends status words or buffer samples on the 32-bit stream with keep and last
 */
`timescale 1ns/1ps
`default_nettype none
`include "scope_defs.svh"

module resp_stream_tx import scope_acq_pkg::*; (
	input  logic                       clk,
	input  logic                       rstn,
	input  logic                       i_resp_start,
	input  logic [`SCOPE_WORD_W-1:0]   i_resp_word,
	input  logic [`SCOPE_LEN_W-1:0]    i_resp_bytes,
	input  logic                       i_resp_is_buf,
	input  buf_addr_t                  i_resp_addr,
	output buf_addr_t                  o_rd_addr,
	input  sample_t [1:0]              i_rd_data,
	output logic                       o_tx_tvalid,
	output logic [`SCOPE_WORD_W-1:0]   o_tx_tdata,
	output logic [`SCOPE_WORD_W/8-1:0] o_tx_tkeep,
	output logic                       o_tx_tlast,
	input  logic                       i_tx_tready,
	output logic                       o_resp_done,
	output logic                       o_readout_done
);

	localparam int KEEP_W  = `SCOPE_WORD_W / 8;
	localparam int KEEP_LG = $clog2(KEEP_W);
	localparam int PAD     = `SCOPE_WORD_W / 2 - `SCOPE_SAMPLE_W;
	localparam buf_addr_t STEP = buf_addr_t'(2); // two samples per word

	logic [`SCOPE_LEN_W-1:0]  remain; // bytes not yet accepted
	logic                     is_buf, fresh, accept, start_ok;
	buf_addr_t                addr_q;
	logic [`SCOPE_WORD_W-1:0] word_q, data_q, rd_word;

	assign start_ok = i_resp_start && !o_tx_tvalid;
	assign accept   = o_tx_tvalid && i_tx_tready;
	assign rd_word  = {{PAD{1'b0}}, i_rd_data[1], {PAD{1'b0}}, i_rd_data[0]};

	// read one word ahead so data is there on the next cycle
	assign o_rd_addr  = start_ok ? i_resp_addr : (accept ? addr_q + STEP : addr_q);
	assign o_tx_tdata = !is_buf ? word_q : (fresh ? rd_word : data_q);
	assign o_tx_tlast = remain <= KEEP_W;

	always_comb begin
		if (remain >= KEEP_W) o_tx_tkeep = '1;
		else o_tx_tkeep = KEEP_W'((1 << remain[KEEP_LG-1:0]) - 1); // partial tail
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_tx_tvalid    <= 1'b0;
			fresh          <= 1'b0;
			is_buf         <= 1'b0;
			remain         <= '0;
			o_resp_done    <= 1'b0;
			o_readout_done <= 1'b0;
		end else begin
			o_resp_done    <= 1'b0;
			o_readout_done <= 1'b0;
			fresh          <= 1'b0; // first cycle of a word only
			if (start_ok) begin
				o_tx_tvalid <= 1'b1;
				fresh       <= 1'b1;
				remain      <= i_resp_bytes;
				is_buf      <= i_resp_is_buf;
			end else if (accept) begin
				if (o_tx_tlast) begin
					o_tx_tvalid    <= 1'b0;
					o_resp_done    <= 1'b1;
					o_readout_done <= is_buf; // lets trigger re-arm
				end else begin
					remain <= remain - `SCOPE_LEN_W'(KEEP_W);
					fresh  <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_ok) begin
			addr_q <= i_resp_addr;
			word_q <= i_resp_word;
		end else if (accept) begin
			addr_q <= addr_q + STEP;
		end
		if (fresh) data_q <= rd_word; // hold against ram writes while stalled
	end

endmodule

`default_nettype wire

// File: src/sample_ram.sv
/*
 * sample ring buffer
 * one write port, registered read of two adjacent samples
 */
`timescale 1ns/1ps
`default_nettype none
`include "scope_defs.svh"

module sample_ram import scope_acq_pkg::*; (
	input  logic          clk,
	input  logic          i_wr_en,
	input  buf_addr_t     i_wr_addr,
	input  sample_t       i_wr_data,
	input  buf_addr_t     i_rd_addr,
	output sample_t [1:0] o_rd_data
);

	localparam int DEPTH = 1 << `SCOPE_ADDR_W;

	sample_t   mem [DEPTH];
	buf_addr_t rd_next;

	assign rd_next = i_rd_addr + 1'b1; // wraps to entry 0

	always_ff @(posedge clk) begin
		if (i_wr_en) mem[i_wr_addr] <= i_wr_data;
		o_rd_data[0] <= mem[i_rd_addr];
		o_rd_data[1] <= mem[rd_next];
	end

endmodule

`default_nettype wire

// File: src/scope_acq_pkg.sv
/*
 * acquisition types
 * sample word, ring address and trigger state codes
 */
`default_nettype none
`include "scope_defs.svh"

package scope_acq_pkg;

	typedef logic signed [`SCOPE_SAMPLE_W-1:0] sample_t;
	typedef logic [`SCOPE_ADDR_W-1:0] buf_addr_t;

	// codes match what the host software decodes
	typedef enum logic [7:0] {
		READY     = 8'd0,
		WAIT_LOW  = 8'd1,   // waiting for signal below lower
		WAIT_HIGH = 8'd2,   // armed, waiting to cross upper
		POST      = 8'd250, // taking post-trigger samples
		DONE      = 8'd251  // frozen until read out
	} acq_state_t;

endpackage

`default_nettype wire

// File: src/scope_cmd_pkg.sv
/*
 * host command types
 * opcodes and the two decodings of an 8-byte command frame
 */
`default_nettype none
`include "scope_defs.svh"

package scope_cmd_pkg;

	typedef enum logic [7:0] {
		RD_BUF   = 8'd0, // stream samples from the ring
		ARM      = 8'd1, // arm trigger, return status
		RD_INFO  = 8'd2, // firmware version
		TRIG_SET = 8'd8  // thresholds and pre-offset
	} opcode_t;

	// byte 0 lowest, length little endian in bytes 4..7
	typedef struct packed {
		logic [31:0] length;    // bytes for readout, samples for arm
		logic [15:0] rsvd;
		logic [7:0]  trig_type; // 0 immediate, 1 rising threshold
		opcode_t     opcode;
	} cmd_rd_t;

	typedef struct packed {
		logic [23:0] unused;
		logic [7:0]  preoff_lo;
		logic [7:0]  preoff_hi;
		logic [7:0]  hyst;   // hysteresis in adc/16 steps
		logic [7:0]  centre; // 128 is mid scale
		opcode_t     opcode;
	} cmd_cfg_t;

	typedef union packed {
		cmd_rd_t                                rd;
		cmd_cfg_t                               cfg;
		logic [`SCOPE_FRAME_BYTES-1:0][7:0] raw; // as received
	} cmd_frame_u;

endpackage

`default_nettype wire

// File: src/scope_defs.svh
/*
 * scope controller constants
 * sample and word widths, ring buffer depth, command size, firmware version
 */
`ifndef SCOPE_DEFS_SVH
`define SCOPE_DEFS_SVH

// ------------------------------
// data path widths
`define SCOPE_SAMPLE_W    12 // adc sample bits
`define SCOPE_WORD_W      32 // response stream word
`define SCOPE_LEN_W       32 // byte count of a response
`define SCOPE_CNT_W       16 // post-trigger length and event count

// ------------------------------
// buffer and command framing
`define SCOPE_ADDR_W      6  // 64 sample ring
`define SCOPE_FRAME_BYTES 8  // host command size

// reported by the info command
`define SCOPE_VERSION     18

`endif

// File: src/scope_top.sv
/*
 * scope controller top
 * command receive and execute, response stream, trigger and sample ring
 */
`timescale 1ns/1ps
`default_nettype none
`include "scope_defs.svh"

module scope_top import scope_cmd_pkg::*; import scope_acq_pkg::*; (
	input  logic                       clk,
	input  logic                       rstn,
	input  logic                       i_rx_tvalid,
	input  logic [7:0]                 i_rx_tdata,
	output logic                       o_rx_tready,
	output logic                       o_tx_tvalid,
	output logic [`SCOPE_WORD_W-1:0]   o_tx_tdata,
	output logic [`SCOPE_WORD_W/8-1:0] o_tx_tkeep,
	output logic                       o_tx_tlast,
	input  logic                       i_tx_tready,
	input  logic                       i_smp_valid,
	input  sample_t                    i_smp
);

	// ------------------------------
	// command side
	cmd_frame_u              frame;
	logic                    frame_valid, cmd_done;
	logic                    arm;
	logic [7:0]              arm_type;
	logic [`SCOPE_CNT_W-1:0] post_len, event_count;
	sample_t                 lower, upper;

	// ------------------------------
	// response and acquisition side
	logic                     resp_start, resp_is_buf, resp_done, readout_done;
	logic [`SCOPE_WORD_W-1:0] resp_word;
	logic [`SCOPE_LEN_W-1:0]  resp_bytes;
	buf_addr_t                resp_addr, rd_addr, wr_addr, trig_addr;
	sample_t [1:0]            rd_data;
	sample_t                  wr_data;
	logic                     wr_en;
	acq_state_t               acq_state;

	cmd_frame_rx u_rx (
		.clk(clk), .rstn(rstn),
		.i_rx_tvalid(i_rx_tvalid), .i_rx_tdata(i_rx_tdata), .o_rx_tready(o_rx_tready),
		.o_frame(frame), .o_frame_valid(frame_valid), .i_cmd_done(cmd_done)
	);

	cmd_exec u_exec (
		.clk(clk), .rstn(rstn),
		.i_frame(frame), .i_frame_valid(frame_valid), .o_cmd_done(cmd_done),
		.o_arm(arm), .o_arm_type(arm_type), .o_post_len(post_len),
		.o_lower(lower), .o_upper(upper),
		.i_acq_state(acq_state), .i_event_count(event_count), .i_trig_addr(trig_addr),
		.o_resp_start(resp_start), .o_resp_word(resp_word), .o_resp_bytes(resp_bytes),
		.o_resp_is_buf(resp_is_buf), .o_resp_addr(resp_addr), .i_resp_done(resp_done)
	);

	resp_stream_tx u_tx (
		.clk(clk), .rstn(rstn),
		.i_resp_start(resp_start), .i_resp_word(resp_word), .i_resp_bytes(resp_bytes),
		.i_resp_is_buf(resp_is_buf), .i_resp_addr(resp_addr),
		.o_rd_addr(rd_addr), .i_rd_data(rd_data),
		.o_tx_tvalid(o_tx_tvalid), .o_tx_tdata(o_tx_tdata), .o_tx_tkeep(o_tx_tkeep),
		.o_tx_tlast(o_tx_tlast), .i_tx_tready(i_tx_tready),
		.o_resp_done(resp_done), .o_readout_done(readout_done)
	);

	trigger_fsm u_trig (
		.clk(clk), .rstn(rstn),
		.i_smp_valid(i_smp_valid), .i_smp(i_smp),
		.i_arm(arm), .i_arm_type(arm_type), .i_post_len(post_len),
		.i_lower(lower), .i_upper(upper), .i_readout_done(readout_done),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
		.o_acq_state(acq_state), .o_event_count(event_count), .o_trig_addr(trig_addr)
	);

	sample_ram u_ram (
		.clk(clk),
		.i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
		.i_rd_addr(rd_addr), .o_rd_data(rd_data)
	);

endmodule

`default_nettype wire

// File: src/trigger_fsm.sv
/*
 * trigger and acquisition FSM
 * ring buffer write addressing, threshold trigger and post-trigger count
 */
`timescale 1ns/1ps
`default_nettype none
`include "scope_defs.svh"

module trigger_fsm import scope_acq_pkg::*; (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic                    i_smp_valid,
	input  sample_t                 i_smp,
	input  logic                    i_arm,
	input  logic [7:0]              i_arm_type,
	input  logic [`SCOPE_CNT_W-1:0] i_post_len,
	input  sample_t                 i_lower,
	input  sample_t                 i_upper,
	input  logic                    i_readout_done,
	output logic                    o_wr_en,
	output buf_addr_t               o_wr_addr,
	output sample_t                 o_wr_data,
	output acq_state_t              o_acq_state,
	output logic [`SCOPE_CNT_W-1:0] o_event_count,
	output buf_addr_t               o_trig_addr
);

	acq_state_t              state;
	buf_addr_t               wr_addr;
	logic [`SCOPE_CNT_W-1:0] post_cnt; // samples taken since trigger
	logic                    post_end;

	assign o_wr_en     = i_smp_valid && (state != DONE); // buffer frozen in done
	assign o_wr_addr   = wr_addr;
	assign o_wr_data   = i_smp;
	assign o_acq_state = state;

	// finish on the sample that completes the count
	assign post_end = (post_cnt >= i_post_len) ||
		(i_smp_valid && (post_cnt + 1'b1 >= i_post_len));

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state         <= READY;
			wr_addr       <= '0;
			post_cnt      <= '0;
			o_event_count <= '0;
			o_trig_addr   <= '0;
		end else begin
			if (o_wr_en) wr_addr <= wr_addr + 1'b1; // ring wraps at 64

			case (state)
				READY: begin
					post_cnt <= '0;
					if (i_arm) begin
						if (i_arm_type == 8'd1) begin
							state <= WAIT_LOW;
						end else begin
							o_trig_addr <= wr_addr; // forced trigger, here and now
							state       <= POST;
						end
					end
				end
				WAIT_LOW: begin
					if (i_smp_valid && (i_smp < i_lower)) state <= WAIT_HIGH;
				end
				WAIT_HIGH: begin
					if (i_smp_valid && (i_smp > i_upper)) begin
						o_trig_addr <= wr_addr; // where this sample goes
						state       <= POST;
					end
				end
				POST: begin
					if (i_smp_valid) post_cnt <= post_cnt + 1'b1;
					if (post_end) begin
						o_event_count <= o_event_count + 1'b1;
						state         <= DONE;
					end
				end
				DONE: begin
					if (i_readout_done) state <= READY;
				end
				default: state <= READY;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: test/tb_scope.sv
/*
 * testbench for the scope controller
 * table of host commands with a ring buffer model, random tx back-pressure
 */
`timescale 1ns/1ps
`default_nettype none
`include "scope_defs.svh"

module tb_scope import scope_acq_pkg::*; ();

	localparam int NROW  = 12;
	localparam int DEPTH = 1 << `SCOPE_ADDR_W;

	logic       clk, rstn;
	logic       i_rx_tvalid, o_rx_tready;
	logic [7:0] i_rx_tdata;
	logic       o_tx_tvalid, o_tx_tlast, i_tx_tready;
	logic [31:0] o_tx_tdata;
	logic [3:0] o_tx_tkeep;
	logic       i_smp_valid;
	sample_t    i_smp;

	// ------------------------------
	// stimulus table, word 0 in the low bits
	string        row_name  [NROW];
	logic [63:0]  row_cmd   [NROW]; // byte 0 in bits 7:0
	int           row_nsmp  [NROW];
	int           row_start [NROW];
	int           row_step  [NROW];
	int           row_nword [NROW];
	logic         row_model [NROW]; // data comes from ring model
	logic [127:0] row_words [NROW];
	logic [15:0]  row_keeps [NROW];
	logic [3:0]   row_lasts [NROW];
	int           nrows = 0;

	// ring buffer and trigger model
	logic [11:0] m_mem [DEPTH];
	acq_state_t  m_state = READY;
	int          m_wr = 0, m_trig = 0, m_cnt = 0, m_len = 0;
	int          m_lower = 0, m_upper = 0, m_preoff = 0;

	logic [31:0] got_word [8];
	logic [3:0]  got_keep [8];
	logic        got_last [8];
	int          got_n;
	logic [31:0] lfsr = 32'hb7d8bf77;
	int          cur, row_errors, errors = 0, failed = 0, checks = 0;
	int          cycles = 0, limit = 0;

	scope_top u_dut (
		.clk(clk), .rstn(rstn),
		.i_rx_tvalid(i_rx_tvalid), .i_rx_tdata(i_rx_tdata), .o_rx_tready(o_rx_tready),
		.o_tx_tvalid(o_tx_tvalid), .o_tx_tdata(o_tx_tdata), .o_tx_tkeep(o_tx_tkeep),
		.o_tx_tlast(o_tx_tlast), .i_tx_tready(i_tx_tready),
		.i_smp_valid(i_smp_valid), .i_smp(i_smp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// run limit, counted on every edge
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic add_row(input string name, input logic [63:0] cmd, input int nsmp,
		input int start, input int step, input int nword, input logic model,
		input logic [127:0] words, input logic [15:0] keeps, input logic [3:0] lasts);
		row_name[nrows]  = name;
		row_cmd[nrows]   = cmd;
		row_nsmp[nrows]  = nsmp;
		row_start[nrows] = start;
		row_step[nrows]  = step;
		row_nword[nrows] = nword;
		row_model[nrows] = model;
		row_words[nrows] = words;
		row_keeps[nrows] = keeps;
		row_lasts[nrows] = lasts;
		nrows++;
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // taps 32 22 2 1
		return {s[30:0], fb};
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (exp === act) else begin
			$display("CHECK FAILED %s %s expected %h actual %h", row_name[cur], what, exp, act);
			row_errors++;
		end
	endtask

	// ------------------------------
	// model of ring writes and trigger
	task automatic model_sample(input int v);
		sample_t s;
		int      sv, a;
		s  = sample_t'(v);
		sv = int'(s);
		a  = m_wr;
		if (m_state != DONE) begin
			m_mem[a] = s;
			m_wr     = (a + 1) % DEPTH;
		end
		case (m_state)
			WAIT_LOW: if (sv < m_lower) m_state = WAIT_HIGH;
			WAIT_HIGH: if (sv > m_upper) begin
				m_trig  = a; // address of the crossing sample
				m_cnt   = 0;
				m_state = POST;
			end
			POST: begin
				m_cnt++;
				if (m_cnt >= m_len) m_state = DONE;
			end
			default: ;
		endcase
	endtask

	task automatic model_command(input logic [63:0] cmd);
		int c, h;
		c = int'(cmd[15:8]);
		h = int'(cmd[23:16]);
		if (cmd[7:0] == 8'd8) begin
			m_lower  = int'(sample_t'((c - h - 128) * 16 + 8));
			m_upper  = int'(sample_t'((c + h - 128) * 16 + 8));
			m_preoff = int'({cmd[31:24], cmd[39:32]}) % DEPTH;
		end else if (cmd[7:0] == 8'd1 && m_state == READY) begin
			m_len = int'(cmd[47:32]);
			if (cmd[15:8] == 8'd1) begin
				m_state = WAIT_LOW;
			end else begin
				m_trig  = m_wr; // forced trigger
				m_cnt   = 0;
				m_state = POST;
			end
		end else if (cmd[7:0] == 8'd0 && m_state == DONE) begin
			m_state = READY; // readout releases the buffer
		end
	endtask

	function automatic logic [31:0] readout_word(input int w);
		int a;
		a = (m_trig - m_preoff + 2 * w + 2 * DEPTH) % DEPTH;
		return {4'h0, m_mem[(a + 1) % DEPTH], 4'h0, m_mem[a]};
	endfunction

	// ------------------------------
	// stream drivers
	task automatic feed_samples(input int n, input int start, input int step);
		int k;
		for (k = 0; k < n; k++) begin
			@(posedge clk);
			i_smp_valid <= 1'b1;
			i_smp       <= sample_t'(start + k * step);
			model_sample(start + k * step);
		end
		@(posedge clk);
		i_smp_valid <= 1'b0;
	endtask

	task automatic send_frame(input logic [63:0] cmd);
		int i;
		i = 0;
		while (i < 8) begin
			@(posedge clk);
			i_rx_tvalid <= 1'b1;
			i_rx_tdata  <= cmd[8*i +: 8];
			@(negedge clk);
			if (o_rx_tready) i++; // taken on the coming edge
		end
		@(posedge clk);
		i_rx_tvalid <= 1'b0;
	endtask

	// gathers words until the receiver opens for the next command
	task automatic collect_response();
		logic        held;
		logic [31:0] held_data;
		held  = 1'b0;
		got_n = 0;
		do begin
			@(posedge clk);
			lfsr = lfsr_next(lfsr);
			i_tx_tready <= lfsr[0]; // random back-pressure
			@(negedge clk);
			if (held) begin
				check_value("held valid", 32'd1, 32'(o_tx_tvalid));
				check_value("held data", held_data, o_tx_tdata);
			end
			held      = o_tx_tvalid && !i_tx_tready;
			held_data = o_tx_tdata;
			if (o_tx_tvalid && i_tx_tready && got_n < 8) begin
				got_word[got_n] = o_tx_tdata;
				got_keep[got_n] = o_tx_tkeep;
				got_last[got_n] = o_tx_tlast;
				got_n++;
			end
		end while (!o_rx_tready);
	endtask

	initial begin
		int          r, w;
		logic [31:0] exp_word [4];
		rstn        = 1'b0;
		i_rx_tvalid = 1'b0;
		i_rx_tdata  = 8'd0;
		i_tx_tready = 1'b0;
		i_smp_valid = 1'b0;
		i_smp       = '0;

		// centre 128, hysteresis 4, pre-offset 2
		add_row("info", 64'h0000_0000_0000_0002, 0, 0, 0, 1, 0, 128'd18, 16'hF, 4'b1);
		add_row("trig_set", 64'h0000_0002_0004_8008, 0, 0, 0, 1, 0, 128'd8, 16'hF, 4'b1);
		add_row("arm_idle", 64'h0000_000A_0000_0001, 70, 0, 37, 1, 0, 128'h0, 16'hF, 4'b1);
		add_row("status_done", 64'h0000_000A_0000_0001, 20, 500, 3, 1, 0,
			128'h0001_00FB, 16'hF, 4'b1);
		add_row("read_forced", 64'h0000_0008_0000_0000, 0, 0, 0, 2, 1, '0, 16'hFF, 4'b0010);
		add_row("arm_rising", 64'h0000_0008_0000_0101, 0, 0, 0, 1, 0,
			128'h0001_0000, 16'hF, 4'b1);
		add_row("status_wait", 64'h0000_0008_0000_0101, 10, 0, -16, 1, 0,
			128'h0001_0002, 16'hF, 4'b1);
		add_row("status_fired", 64'h0000_0008_0000_0101, 20, -100, 16, 1, 0,
			128'h0002_00FB, 16'hF, 4'b1);
		add_row("read_trig", 64'h0000_0010_0000_0000, 0, 0, 0, 4, 1, '0, 16'hFFFF, 4'b1000);
		add_row("read_short", 64'h0000_0006_0000_0000, 0, 0, 0, 2, 1, '0, 16'h3F, 4'b0010);
		add_row("unknown_op", 64'h0000_0000_0000_0055, 0, 0, 0, 0, 0, '0, 16'h0, 4'b0);
		add_row("info_again", 64'h0000_0000_0000_0002, 0, 0, 0, 1, 0, 128'd18, 16'hF, 4'b1);

		for (r = 0; r < nrows; r++) limit += row_nsmp[r] + 16 * row_nword[r] + 40;
		limit = 2 * limit;

		repeat (16) @(posedge clk);
		rstn <= 1'b1;

		for (r = 0; r < nrows; r++) begin
			cur        = r;
			row_errors = 0;
			feed_samples(row_nsmp[r], row_start[r], row_step[r]);
			for (w = 0; w < 4; w++) begin
				exp_word[w] = row_model[r] ? readout_word(w) : row_words[r][32*w +: 32];
			end
			send_frame(row_cmd[r]);
			collect_response();
			check_value("word count", 32'(row_nword[r]), 32'(got_n));
			for (w = 0; w < row_nword[r] && w < got_n; w++) begin
				check_value("data", exp_word[w], got_word[w]);
				check_value("keep", 32'(row_keeps[r][4*w +: 4]), 32'(got_keep[w]));
				check_value("last", 32'(row_lasts[r][w]), 32'(got_last[w]));
			end
			model_command(row_cmd[r]);
			if (row_errors != 0) failed++;
			errors += row_errors;
			$display("%s: %s", row_name[r], (row_errors == 0) ? "ok" : "failed");
		end

		$display("tests %0d, failed %0d, checks %0d, errors %0d", nrows, failed, checks,
			errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
